/* hw/wisc_consts.svh */
/*
 * WISC-F24 core constants
 * Word and address widths, register count and memory depths
 */

`ifndef WISC_CONSTS_SVH
`define WISC_CONSTS_SVH

// Datapath widths
`define WISC_DWIDTH 16
`define WISC_AWIDTH 16

// Architectural register count
`define WISC_NREGS 16

// Memory depths in 16-bit words
`define WISC_IMEM_WORDS 512
`define WISC_DMEM_WORDS 512

`endif

/* hw/wisc_pkg.sv */
/*
 * WISC-F24 shared types
 * Words, addresses, register indices, opcodes, branch conditions and flags
 */

package wisc_pkg;

`include "wisc_consts.svh"

    typedef logic [`WISC_DWIDTH-1:0] word_t;
    typedef logic [`WISC_AWIDTH-1:0] addr_t;
    typedef logic [$clog2(`WISC_NREGS)-1:0] reg_idx_t;

    // Instruction bits [15:12]
    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_XOR    = 4'd2,
        OP_RED    = 4'd3,
        OP_SLL    = 4'd4,
        OP_SRA    = 4'd5,
        OP_ROR    = 4'd6,
        OP_PADDSB = 4'd7,
        OP_LW     = 4'd8,
        OP_SW     = 4'd9,
        OP_LLB    = 4'd10,
        OP_LHB    = 4'd11,
        OP_B      = 4'd12,
        OP_BR     = 4'd13,
        OP_PCS    = 4'd14,
        OP_HLT    = 4'd15
    } opcode_t;

    // Branch condition field, bits [11:9]
    typedef enum logic [2:0] {
        COND_NEQ, COND_EQ, COND_GT, COND_LT,
        COND_GTE, COND_LTE, COND_OVFL, COND_UNCOND
    } cond_t;

    typedef struct packed {
        logic zero;
        logic ovfl;
        logic sign;
    } flags_t;

    // Same encoding as the low three bits of the compute opcodes
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_RED,
        ALU_SLL, ALU_SRA, ALU_ROR, ALU_PADDSB
    } alu_op_t;

endpackage

/* hw/wisc_mem.sv */
/*
 * WISC-F24 word memory
 * Byte-addressed 16-bit words, asynchronous read and optional clocked write.
 * Serves as both instruction and data memory.
 */

`timescale 1ns/1ps

`include "wisc_consts.svh"

module wisc_mem
    import wisc_pkg::*;
#(
    parameter int DEPTH    = `WISC_DMEM_WORDS,
    parameter bit WRITABLE = 1'b1
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  wr,
    input  addr_t addr,
    input  word_t wdata,
    output word_t rdata
);

    localparam int IDX_W = $clog2(DEPTH);

    word_t mem [DEPTH];
    logic [IDX_W-1:0] idx;

    // Word index, bit 0 of the byte address is ignored
    assign idx = addr[IDX_W:1];

    assign rdata = mem[idx];

    always_ff @(posedge clk) begin
        if (WRITABLE && wr) begin
            mem[idx] <= wdata;
        end
    end

    // --------------------
    // Checks
    // --------------------
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr |-> !$isunknown(addr)
    );

endmodule

/* hw/wisc_regfile.sv */
/*
 * WISC-F24 register file
 * Sixteen 16-bit registers, two read ports and one write port.
 * R0 always reads as zero.
 */

`timescale 1ns/1ps

`include "wisc_consts.svh"

module wisc_regfile
    import wisc_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     we,
    input  word_t    wdata,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [`WISC_NREGS];

    // Writes land on the clock edge, the next instruction reads them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Read ports
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    // --------------------
    // Checks
    // --------------------
    a_we_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(we)
    );

endmodule

/* hw/wisc_alu.sv */
/*
 * WISC-F24 arithmetic/logic unit
 * Saturating add/sub, XOR, byte reduction, shifts, rotate and nibble-wise
 * saturating add, plus the flag values for the result.
 */

`timescale 1ns/1ps

module wisc_alu
    import wisc_pkg::*;
(
    input  alu_op_t    op,
    input  word_t      a,
    input  word_t      b,
    input  logic [3:0] imm4,
    output word_t      result,
    output flags_t     flags_next
);

    // One 4-bit lane, clamped to [-8, 7]
    function automatic logic [3:0] sat_nibble(input logic [3:0] x, input logic [3:0] y);
        logic [3:0] s;
        s = x + y;
        if (x[3] == y[3] && s[3] != x[3]) begin
            s = x[3] ? 4'h8 : 4'h7;
        end
        return s;
    endfunction

    word_t       sum;
    word_t       diff;
    logic        add_ovf;
    logic        sub_ovf;
    word_t       add_sat;
    word_t       sub_sat;
    logic [9:0]  red_sum;
    logic [31:0] rot;
    word_t       padd;

    // --------------------
    // Add and subtract
    // --------------------
    assign sum     = a + b;
    assign diff    = a - b;
    assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
    assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);

    // Clamp towards the sign of operand a
    assign add_sat = add_ovf ? (a[15] ? 16'h8000 : 16'h7fff) : sum;
    assign sub_sat = sub_ovf ? (a[15] ? 16'h8000 : 16'h7fff) : diff;

    // --------------------
    // Reduction and lanes
    // --------------------
    assign red_sum = {{2{a[15]}}, a[15:8]} + {{2{a[7]}}, a[7:0]}
                   + {{2{b[15]}}, b[15:8]} + {{2{b[7]}}, b[7:0]};

    assign padd = {sat_nibble(a[15:12], b[15:12]), sat_nibble(a[11:8], b[11:8]),
                   sat_nibble(a[7:4], b[7:4]), sat_nibble(a[3:0], b[3:0])};

    // Rotate right via a doubled word
    assign rot = {a, a} >> imm4;

    always_comb begin
        case (op)
            ALU_ADD:    result = add_sat;
            ALU_SUB:    result = sub_sat;
            ALU_XOR:    result = a ^ b;
            ALU_RED:    result = {{6{red_sum[9]}}, red_sum};
            ALU_SLL:    result = a << imm4;
            ALU_SRA:    result = $signed(a) >>> imm4;
            ALU_ROR:    result = rot[15:0];
            ALU_PADDSB: result = padd;
            default:    result = '0;
        endcase
    end

    // Overflow and sign only mean something for ADD and SUB
    always_comb begin
        flags_next.zero = (result == '0);
        flags_next.ovfl = 1'b0;
        flags_next.sign = 1'b0;
        if (op == ALU_ADD) begin
            flags_next.ovfl = add_ovf;
            flags_next.sign = result[15];
        end else if (op == ALU_SUB) begin
            flags_next.ovfl = sub_ovf;
            flags_next.sign = result[15];
        end
    end

endmodule

/* hw/wisc_control.sv */
/*
 * WISC-F24 main decoder
 * Turns the opcode into datapath control levels and the flag-update mask
 */

`timescale 1ns/1ps

module wisc_control
    import wisc_pkg::*;
(
    input  opcode_t opcode,
    output logic    reg_write,
    output logic    alu_src,
    output logic    mem_read,
    output logic    mem_write,
    output logic    mem_to_reg,
    output logic    llb,
    output logic    lhb,
    output logic    branch,
    output logic    branch_reg,
    output logic    pcs,
    output logic    halt,
    output flags_t  flag_mask
);

    always_comb begin
        reg_write  = 1'b0;
        alu_src    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        llb        = 1'b0;
        lhb        = 1'b0;
        branch     = 1'b0;
        branch_reg = 1'b0;
        pcs        = 1'b0;
        halt       = 1'b0;
        flag_mask  = '0;

        case (opcode)
            OP_ADD, OP_SUB: begin
                reg_write = 1'b1;
                flag_mask = '{zero: 1'b1, ovfl: 1'b1, sign: 1'b1};
            end
            // Remaining compute ops touch Z only
            OP_XOR, OP_RED, OP_SLL, OP_SRA, OP_ROR, OP_PADDSB: begin
                reg_write      = 1'b1;
                flag_mask.zero = 1'b1;
            end
            OP_LW: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            OP_LLB: begin
                reg_write = 1'b1;
                llb       = 1'b1;
            end
            OP_LHB: begin
                reg_write = 1'b1;
                lhb       = 1'b1;
            end
            OP_B:  branch = 1'b1;
            OP_BR: begin
                branch     = 1'b1;
                branch_reg = 1'b1;
            end
            OP_PCS: begin
                reg_write = 1'b1;
                pcs       = 1'b1;
            end
            default: halt = 1'b1;
        endcase

        a_mem_excl: assert final (!(mem_read && mem_write));
    end

endmodule

/* hw/wisc_fetch.sv */
/*
 * WISC-F24 fetch and branch unit
 * Holds PC and flags, evaluates branch conditions and picks the next PC.
 * Freezes while halted or while run is low.
 */

`timescale 1ns/1ps

module wisc_fetch
    import wisc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  logic       halt,
    input  logic       branch,
    input  logic       branch_reg,
    input  cond_t      cond,
    input  logic [8:0] offset,
    input  word_t      reg_target,
    input  flags_t     flags_next,
    input  flags_t     flag_mask,
    output addr_t      pc,
    output addr_t      pc_plus2
);

    flags_t flags_q;
    logic   taken;
    logic   commit;
    addr_t  pc_next;
    addr_t  imm_target;

    assign commit   = run && !halt;
    assign pc_plus2 = pc + 16'd2;

    // Offset counts words from the following instruction
    assign imm_target = pc_plus2 + {{6{offset[8]}}, offset, 1'b0};

    // --------------------
    // Condition check
    // --------------------
    always_comb begin
        case (cond)
            COND_NEQ:  taken = !flags_q.zero;
            COND_EQ:   taken = flags_q.zero;
            COND_GT:   taken = !flags_q.zero && !flags_q.sign;
            COND_LT:   taken = flags_q.sign;
            COND_GTE:  taken = flags_q.zero || !flags_q.sign;
            COND_LTE:  taken = flags_q.zero || flags_q.sign;
            COND_OVFL: taken = flags_q.ovfl;
            default:   taken = 1'b1;
        endcase
    end

    always_comb begin
        pc_next = pc_plus2;
        if (branch && taken) begin
            // Register target forced to a word boundary
            pc_next = branch_reg ? {reg_target[15:1], 1'b0} : imm_target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= '0;
            flags_q <= '0;
        end else if (commit) begin
            pc <= pc_next;
            flags_q.zero <= flag_mask.zero ? flags_next.zero : flags_q.zero;
            flags_q.ovfl <= flag_mask.ovfl ? flags_next.ovfl : flags_q.ovfl;
            flags_q.sign <= flag_mask.sign ? flags_next.sign : flags_q.sign;
        end
    end

    // --------------------
    // Checks
    // --------------------
    a_pc_even: assert property (@(posedge clk) disable iff (!rst_n) pc[0] == 1'b0);

endmodule

/* hw/wisc_cpu.sv */
/*
 * WISC-F24 single-cycle CPU
 * Fetch, memories, decoder, register file and ALU with the writeback
 * muxes and the program-load path into instruction memory
 */

`timescale 1ns/1ps

`include "wisc_consts.svh"

module wisc_cpu
    import wisc_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    run,
    input  logic                    prog_we,
    input  logic [`WISC_AWIDTH-2:0] prog_addr,
    input  word_t                   prog_data,
    output logic                    hlt,
    output addr_t                   pc
);

    word_t    instr, rdata1, rdata2, alu_a, alu_b, alu_result, mem_rdata, wb_data;
    addr_t    pc_plus2, imem_addr;
    opcode_t  opcode;
    reg_idx_t rs2;
    alu_op_t  alu_op;
    flags_t   flags_next, flag_mask;
    logic     reg_write, alu_src, mem_read, mem_write, mem_to_reg;
    logic     llb, lhb, branch, branch_reg, pcs, halt;
    logic     commit;

    assign commit = run && !halt;
    assign hlt    = halt;
    assign opcode = opcode_t'(instr[15:12]);

    // --------------------
    // Fetch
    // --------------------
    wisc_fetch fetch_inst (
        .clk(clk), .rst_n(rst_n), .run(run), .halt(halt),
        .branch(branch), .branch_reg(branch_reg), .cond(cond_t'(instr[11:9])),
        .offset(instr[8:0]), .reg_target(rdata1), .flags_next(flags_next),
        .flag_mask(flag_mask), .pc(pc), .pc_plus2(pc_plus2)
    );

    // Loader owns the instruction memory address while prog_we is high
    assign imem_addr = prog_we ? {prog_addr, 1'b0} : pc;

    wisc_mem #(.DEPTH(`WISC_IMEM_WORDS), .WRITABLE(1'b1)) imem (
        .clk(clk), .rst_n(rst_n), .wr(prog_we), .addr(imem_addr),
        .wdata(prog_data), .rdata(instr)
    );

    // --------------------
    // Decode and registers
    // --------------------
    wisc_control control_inst (
        .opcode(opcode), .reg_write(reg_write), .alu_src(alu_src),
        .mem_read(mem_read), .mem_write(mem_write), .mem_to_reg(mem_to_reg),
        .llb(llb), .lhb(lhb), .branch(branch), .branch_reg(branch_reg),
        .pcs(pcs), .halt(halt), .flag_mask(flag_mask)
    );

    // SW data and the LLB/LHB destination both sit in bits [11:8]
    assign rs2 = (mem_write || llb || lhb) ? instr[11:8] : instr[3:0];

    wisc_regfile regfile_inst (
        .clk(clk), .rst_n(rst_n), .rs1(instr[7:4]), .rs2(rs2), .rd(instr[11:8]),
        .we(reg_write && commit), .wdata(wb_data), .rdata1(rdata1), .rdata2(rdata2)
    );

    // --------------------
    // Execute and memory
    // --------------------
    // Address = (base & 0xfffe) + (sext(offset) << 1)
    assign alu_a  = (mem_read || mem_write) ? {rdata1[15:1], 1'b0} : rdata1;
    assign alu_b  = alu_src ? {{11{instr[3]}}, instr[3:0], 1'b0} : rdata2;
    assign alu_op = opcode[3] ? ALU_ADD : alu_op_t'(instr[14:12]);

    wisc_alu alu_inst (
        .op(alu_op), .a(alu_a), .b(alu_b), .imm4(instr[3:0]),
        .result(alu_result), .flags_next(flags_next)
    );

    wisc_mem #(.DEPTH(`WISC_DMEM_WORDS), .WRITABLE(1'b1)) dmem (
        .clk(clk), .rst_n(rst_n), .wr(mem_write && commit), .addr(alu_result),
        .wdata(rdata2), .rdata(mem_rdata)
    );

    // Writeback select
    always_comb begin
        if (pcs) begin
            wb_data = pc_plus2;
        end else if (llb) begin
            wb_data = {rdata2[15:8], instr[7:0]};
        end else if (lhb) begin
            wb_data = {instr[7:0], rdata2[7:0]};
        end else if (mem_to_reg) begin
            wb_data = mem_rdata;
        end else begin
            wb_data = alu_result;
        end
    end

endmodule

/* tests/wisc_cpu_tests.svh */
/*
 * Directed tests for the WISC-F24 CPU
 * Each test assembles a program, runs it and checks the halt PC
 */

// Step limits in clock cycles
localparam int STEPS_HALT  = 16;
localparam int STEPS_ARITH = 128;
localparam int STEPS_SHIFT = 128;
localparam int STEPS_MEM   = 64;
localparam int STEPS_CTRL  = 192;
localparam int STEPS_TOTAL = STEPS_HALT + STEPS_ARITH + STEPS_SHIFT + STEPS_MEM + STEPS_CTRL;

// R11 holds the reference constant, R10 the difference
localparam reg_idx_t REF_REG  = 4'd11;
localparam reg_idx_t DIFF_REG = 4'd10;
localparam word_t    HLT_WORD = {OP_HLT, 12'h000};

// --------------------
// Instruction builders
// --------------------
function automatic word_t rtype(input opcode_t op, input reg_idx_t f1, input reg_idx_t f2,
                                input logic [3:0] f3);
    return {op, f1, f2, f3};
endfunction

function automatic word_t imm8(input opcode_t op, input reg_idx_t rd, input logic [7:0] v);
    return {op, rd, v};
endfunction

function automatic word_t branch_imm(input cond_t c, input int off);
    logic [8:0] off9;
    off9 = off[8:0];
    return {OP_B, c, off9};
endfunction

function automatic word_t branch_reg(input cond_t c, input reg_idx_t rs);
    return {OP_BR, c, 1'b0, rs, 4'h0};
endfunction

// --------------------
// Reference values
// --------------------
function automatic word_t sat16(input int s);
    if (s > 32767) return 16'h7fff;
    if (s < -32768) return 16'h8000;
    return word_t'(s);
endfunction

function automatic word_t paddsb_ref(input word_t a, input word_t b);
    word_t r;
    int    s;
    for (int i = 0; i < 4; i++) begin
        s = int'($signed(a[4*i +: 4])) + int'($signed(b[4*i +: 4]));
        if (s > 7) s = 7;
        else if (s < -8) s = -8;
        r[4*i +: 4] = s[3:0];
    end
    return r;
endfunction

function automatic word_t red_ref(input word_t a, input word_t b);
    int s;
    s = int'($signed(a[15:8])) + int'($signed(a[7:0]))
      + int'($signed(b[15:8])) + int'($signed(b[7:0]));
    return word_t'(s);
endfunction

function automatic word_t sra_ref(input word_t v, input logic [3:0] s);
    word_t r;
    r = v;
    repeat (s) r = {r[15], r[15:1]};
    return r;
endfunction

function automatic word_t ror_ref(input word_t v, input logic [3:0] s);
    word_t r;
    r = v;
    repeat (s) r = {r[0], r[15:1]};
    return r;
endfunction

function automatic logic cond_holds(input cond_t c, input logic z, input logic v, input logic n);
    case (c)
        COND_NEQ:  return !z;
        COND_EQ:   return z;
        COND_GT:   return !z && !n;
        COND_LT:   return n;
        COND_GTE:  return z || !n;
        COND_LTE:  return z || n;
        COND_OVFL: return v;
        default:   return 1'b1;
    endcase
endfunction

// --------------------
// Program assembly
// --------------------
// Word 0 jumps over the fail HLT at byte address 2
task automatic start_program();
    prog.delete();
    prog.push_back(branch_imm(COND_UNCOND, 1));
    prog.push_back(HLT_WORD);
endtask

task automatic end_program(output addr_t pass_pc);
    pass_pc = addr_t'(2 * prog.size());
    prog.push_back(HLT_WORD);
endtask

task automatic put_const(input reg_idx_t rd, input word_t v);
    prog.push_back(imm8(OP_LLB, rd, v[7:0]));
    prog.push_back(imm8(OP_LHB, rd, v[15:8]));
endtask

// Any mismatch lands on the fail HLT
task automatic expect_equal(input reg_idx_t r, input word_t v);
    put_const(REF_REG, v);
    prog.push_back(rtype(OP_SUB, DIFF_REG, r, REF_REG));
    prog.push_back(branch_imm(COND_NEQ, -prog.size()));
endtask

task automatic expect_branch(input cond_t c, input logic taken);
    if (taken) begin
        prog.push_back(branch_imm(c, 1));
        prog.push_back(branch_imm(COND_UNCOND, -prog.size()));
    end else begin
        prog.push_back(branch_imm(c, -prog.size()));
    end
endtask

task automatic run_program(input string name, input addr_t pass_pc, input int steps);
    reset_dut();
    load_program();
    wait_halt(name, steps);
    check_pc(name, pass_pc, pc);
    repeat (3) @(negedge clk);
    check_pc(name, pass_pc, pc);
    check_hlt(name, 1'b1, hlt);
endtask

// --------------------
// Tests
// --------------------
task automatic test_basic_halt();
    prog.delete();
    prog.push_back(HLT_WORD);
    reset_dut();
    load_program();
    repeat (10) begin
        @(negedge clk);
        check_pc("basic_halt", '0, pc);
        check_hlt("basic_halt", 1'b1, hlt);
    end
endtask

task automatic arith_pair(input word_t a, input word_t b);
    int sa;
    int sb;
    sa = int'($signed(a));
    sb = int'($signed(b));
    put_const(4'd1, a);
    put_const(4'd2, b);
    prog.push_back(rtype(OP_ADD, 4'd3, 4'd1, 4'd2));
    prog.push_back(rtype(OP_SUB, 4'd4, 4'd1, 4'd2));
    prog.push_back(rtype(OP_XOR, 4'd5, 4'd1, 4'd2));
    prog.push_back(rtype(OP_PADDSB, 4'd6, 4'd1, 4'd2));
    prog.push_back(rtype(OP_RED, 4'd7, 4'd1, 4'd2));
    expect_equal(4'd3, sat16(sa + sb));
    expect_equal(4'd4, sat16(sa - sb));
    expect_equal(4'd5, a ^ b);
    expect_equal(4'd6, paddsb_ref(a, b));
    expect_equal(4'd7, red_ref(a, b));
endtask

task automatic test_arith();
    word_t a;
    word_t b;
    addr_t pass_pc;
    a = word_t'($random(seed));
    b = word_t'($random(seed));
    start_program();
    arith_pair(a, b);
    // ADD clamps high, every nibble lane clamps
    arith_pair(16'h7788, 16'h4488);
    // SUB clamps low
    arith_pair(16'h8100, 16'h7fff);
    end_program(pass_pc);
    run_program("arith", pass_pc, STEPS_ARITH);
endtask

task automatic shift_case(input word_t v, input logic [3:0] s);
    prog.push_back(rtype(OP_SLL, 4'd2, 4'd1, s));
    prog.push_back(rtype(OP_SRA, 4'd3, 4'd1, s));
    prog.push_back(rtype(OP_ROR, 4'd4, 4'd1, s));
    expect_equal(4'd2, v << s);
    expect_equal(4'd3, sra_ref(v, s));
    expect_equal(4'd4, ror_ref(v, s));
endtask

task automatic test_shifts();
    addr_t pass_pc;
    start_program();
    put_const(4'd1, 16'h9a5c);
    shift_case(16'h9a5c, 4'd0);
    shift_case(16'h9a5c, 4'd3);
    shift_case(16'h9a5c, 4'd8);
    shift_case(16'h9a5c, 4'd15);
    put_const(4'd1, 16'h35a1);
    shift_case(16'h35a1, 4'd5);
    shift_case(16'h35a1, 4'd12);
    end_program(pass_pc);
    run_program("shifts", pass_pc, STEPS_SHIFT);
endtask

task automatic test_memory();
    addr_t pass_pc;
    start_program();
    put_const(4'd1, 16'h0101);
    put_const(4'd2, 16'hbeef);
    put_const(4'd4, 16'h010a);
    // Odd base 0x0101 plus 3 words gives 0x0106
    prog.push_back(rtype(OP_SW, 4'd2, 4'd1, 4'd3));
    // Neighbour word at 0x0104
    prog.push_back(rtype(OP_SW, 4'd1, 4'd4, 4'hd));
    // 0x010a minus 2 words gives 0x0106
    prog.push_back(rtype(OP_LW, 4'd3, 4'd4, 4'he));
    expect_equal(4'd3, 16'hbeef);
    prog.push_back(rtype(OP_SW, 4'd1, 4'd0, 4'd2));
    prog.push_back(rtype(OP_LW, 4'd5, 4'd0, 4'd2));
    expect_equal(4'd5, 16'h0101);
    // Writes to R0 are dropped
    prog.push_back(rtype(OP_ADD, 4'd0, 4'd2, 4'd2));
    prog.push_back(imm8(OP_LLB, 4'd0, 8'h5a));
    prog.push_back(rtype(OP_LW, 4'd0, 4'd4, 4'he));
    expect_equal(4'd0, 16'h0000);
    end_program(pass_pc);
    run_program("memory", pass_pc, STEPS_MEM);
endtask

// ADD sets Z, V and N, a zero XOR then rewrites Z only
task automatic flag_case(input word_t a, input word_t b, input logic zero_xor);
    int   s;
    logic z;
    logic v;
    logic n;
    s = int'($signed(a)) + int'($signed(b));
    v = (s > 32767) || (s < -32768);
    n = (s < 0);
    z = (sat16(s) == 16'h0000) || zero_xor;
    put_const(4'd1, a);
    put_const(4'd2, b);
    prog.push_back(rtype(OP_ADD, 4'd3, 4'd1, 4'd2));
    if (zero_xor) begin
        prog.push_back(rtype(OP_XOR, 4'd5, 4'd1, 4'd1));
    end
    for (int c = 0; c < 8; c++) begin
        expect_branch(cond_t'(c), cond_holds(cond_t'(c), z, v, n));
    end
endtask

task automatic test_control();
    int    call_idx;
    int    sub_idx;
    addr_t pass_pc;
    start_program();
    flag_case(16'h0005, 16'hfffb, 1'b0);
    flag_case(16'h0003, 16'h0004, 1'b0);
    flag_case(16'hfffd, 16'h0001, 1'b0);
    flag_case(16'hfffd, 16'h0001, 1'b1);
    flag_case(16'h7000, 16'h7000, 1'b1);
    // Subroutine call through PCS, return through BR
    put_const(4'd13, 16'h0002);
    call_idx = prog.size();
    prog.push_back({OP_PCS, 4'd14, 8'h00});
    prog.push_back(HLT_WORD);
    expect_equal(4'd12, 16'h0055);
    expect_equal(4'd14, word_t'(2 * call_idx + 4));
    end_program(pass_pc);
    sub_idx = prog.size();
    prog[call_idx + 1] = branch_imm(COND_UNCOND, sub_idx - call_idx - 2);
    prog.push_back(imm8(OP_LLB, 4'd12, 8'h55));
    prog.push_back(rtype(OP_ADD, 4'd14, 4'd14, 4'd13));
    prog.push_back(branch_reg(COND_UNCOND, 4'd14));
    run_program("control", pass_pc, STEPS_CTRL);
endtask

/* tests/wisc_cpu_tb.sv */
/*
 * Testbench for the WISC-F24 CPU
 * Loads small programs through the load port and checks where they halt
 */

`timescale 1ns/1ps

`include "wisc_consts.svh"

module wisc_cpu_tb
    import wisc_pkg::*;
();

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 5;
    localparam int MAX_PROG_WORDS = 160;
    localparam int NUM_TESTS      = 5;

    logic                    clk;
    logic                    rst_n;
    logic                    run;
    logic                    prog_we;
    logic [`WISC_AWIDTH-2:0] prog_addr;
    word_t                   prog_data;
    logic                    hlt;
    addr_t                   pc;

    // Program image built by the test tasks
    word_t  prog[$];
    integer seed;

    wisc_cpu wisc_cpu_inst (
        .clk(clk), .rst_n(rst_n), .run(run), .prog_we(prog_we),
        .prog_addr(prog_addr), .prog_data(prog_data), .hlt(hlt), .pc(pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------
    // Reporting
    // --------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_pc(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED %s: expected pc %h, actual pc %h",
                                name, expected, actual));
        end
    endtask

    task automatic check_hlt(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED %s: expected hlt %b, actual hlt %b",
                                name, expected, actual));
        end
    endtask

    // --------------------
    // Reset, load, wait
    // --------------------
    task automatic reset_dut();
        @(posedge clk);
        rst_n   <= 1'b0;
        run     <= 1'b0;
        prog_we <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // Writes the image with run low, then starts the core
    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= i[`WISC_AWIDTH-2:0];
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        @(posedge clk);
        run <= 1'b1;
    endtask

    task automatic wait_halt(input string name, input int steps);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (hlt !== 1'b1) begin
            if (cycles >= steps) begin
                abort_run($sformatf("%s: core did not halt within %0d cycles", name, steps));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    `include "wisc_cpu_tests.svh"

    // Budget covers every step limit plus reset and load time
    initial begin
        #((STEPS_TOTAL + NUM_TESTS * (MAX_PROG_WORDS + RESET_CYCLES + 8)) * CLK_PERIOD);
        abort_run("Timeout: the run went past the time budget of all tests");
    end

    initial begin
        rst_n     = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        seed      = 9631;
        test_basic_halt();
        test_arith();
        test_shifts();
        test_memory();
        test_control();
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* wisc_cpu.f */
+incdir+hw
+incdir+tests
hw/wisc_pkg.sv
hw/wisc_mem.sv
hw/wisc_regfile.sv
hw/wisc_alu.sv
hw/wisc_control.sv
hw/wisc_fetch.sv
hw/wisc_cpu.sv
tests/wisc_cpu_tb.sv

/* Bender.yml */
package:
  name: wisc_cpu

sources:
  - include_dirs:
      - hw
    files:
      - hw/wisc_pkg.sv
      - hw/wisc_mem.sv
      - hw/wisc_regfile.sv
      - hw/wisc_alu.sv
      - hw/wisc_control.sv
      - hw/wisc_fetch.sv
      - hw/wisc_cpu.sv
  - target: test
    include_dirs:
      - hw
      - tests
    files:
      - tests/wisc_cpu_tb.sv
